/* hdl/vmul_pkg.sv */
////////////////////
// shared types, address map and sizing of the vector multiply coprocessor
// imported by the RTL modules and the register-file interface
////////////////////
package vmul_pkg;

    typedef logic [63:0] bus64_t;

    typedef enum logic [1:0] {VMUL, VMULH, VMULHU, VMULHSU} vmul_op_t;
    typedef enum logic [1:0] {SEW_8, SEW_16, SEW_32, SEW_64} sew_t;
    typedef enum logic [2:0] {IDLE, RD_VS1, RD_VS2, ISSUE, WAIT_MUL, WR_VD} seq_state_t;

    // register file
    localparam int VREG_NUM = 8;
    localparam int VREG_AW  = 3;

    // AXI4-Lite address map
    localparam int AXI_AW = 7;
    localparam int AXI_DW = 64;
    localparam logic [AXI_AW-1:0] VREG_BASE   = 7'h00;
    localparam logic [AXI_AW-1:0] CMD_ADDR    = 7'h40;
    localparam logic [AXI_AW-1:0] STATUS_ADDR = 7'h48;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // command word field offsets, op and sew are 2 bits, registers VREG_AW
    localparam int CMD_OP_LSB  = 0;
    localparam int CMD_SEW_LSB = 2;
    localparam int CMD_VD_LSB  = 4;
    localparam int CMD_VS1_LSB = 7;
    localparam int CMD_VS2_LSB = 10;

    localparam int MUL_LATENCY = 2;

endpackage

/* hdl/vrf_if.sv */
////////////////////
// one access port of the vector register file
// requesters hold their request until a single-cycle gnt
////////////////////
interface vrf_if import vmul_pkg::*; ();

    logic               req;
    logic               we;
    logic [VREG_AW-1:0] addr;
    bus64_t             wdata;
    logic               gnt;
    // valid in the cycle after a read grant
    bus64_t             rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

/* hdl/vmul.sv */
////////////////////
// two-stage SIMD integer multiplier for SEW 8/16/32/64
// result appears MUL_LATENCY cycles after the operands, one op per cycle
////////////////////
module vmul import vmul_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  vmul_op_t op_i,
    input  sew_t     sew_i,
    input  bus64_t   data_vs1_i,
    input  bus64_t   data_vs2_i,
    output bus64_t   data_vd_o
);

    // element magnitudes at the given width, element signs returned in neg
    function automatic bus64_t magnitude(input bus64_t d, input sew_t s, input logic sgn,
                                         output logic [7:0] neg);
        bus64_t m;
        m   = d;
        neg = '0;
        case (s)
            SEW_8: for (int i = 0; i < 8; i++) begin
                neg[i] = sgn & d[i*8+7];
                if (neg[i]) m[i*8+:8] = -d[i*8+:8];
            end
            SEW_16: for (int i = 0; i < 4; i++) begin
                neg[i] = sgn & d[i*16+15];
                if (neg[i]) m[i*16+:16] = -d[i*16+:16];
            end
            SEW_32: for (int i = 0; i < 2; i++) begin
                neg[i] = sgn & d[i*32+31];
                if (neg[i]) m[i*32+:32] = -d[i*32+:32];
            end
            default: begin
                neg[0] = sgn & d[63];
                if (neg[0]) m = -d;
            end
        endcase
        return m;
    endfunction

    ////////////////////
    // stage 0
    ////////////////////
    logic       src1_signed;
    logic       src2_signed;
    logic [7:0] neg1_0;
    logic [7:0] neg2_0;
    bus64_t     mag1_0;
    bus64_t     mag2_0;

    // vmulhsu: vs1 signed, vs2 unsigned
    assign src1_signed = (op_i != VMULHU);
    assign src2_signed = (op_i == VMUL) || (op_i == VMULH);

    always_comb begin
        mag1_0 = magnitude(data_vs1_i, sew_i, src1_signed, neg1_0);
        mag2_0 = magnitude(data_vs2_i, sew_i, src2_signed, neg2_0);
    end

    sew_t       sew_1;
    sew_t       sew_2;
    logic       mulh_1;
    logic       mulh_2;
    logic [7:0] neg_1;
    logic [7:0] neg_2;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_1  <= SEW_8;
            sew_2  <= SEW_8;
            mulh_1 <= 1'b0;
            mulh_2 <= 1'b0;
            neg_1  <= '0;
            neg_2  <= '0;
        end else begin
            sew_1  <= sew_i;
            mulh_1 <= (op_i != VMUL);
            neg_1  <= neg1_0 ^ neg2_0;
            sew_2  <= sew_1;
            mulh_2 <= mulh_1;
            neg_2  <= neg_1;
        end
    end

    ////////////////////
    // stage 1
    ////////////////////
    bus64_t      mag1_1;
    bus64_t      mag2_1;
    logic [15:0] p8  [8][8];
    logic [31:0] p16 [4][4];
    logic [63:0] p32 [2][2];

    // each width built from lo*lo, the two cross terms and hi*hi of the one below
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                p8[i][j] = {8'b0, mag1_1[i*8+:8]} * {8'b0, mag2_1[j*8+:8]};
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                p16[i][j] = {16'b0, p8[2*i][2*j]}
                          + ({16'b0, p8[2*i][2*j+1]} << 8)
                          + ({16'b0, p8[2*i+1][2*j]} << 8)
                          + {p8[2*i+1][2*j+1], 16'b0};
            end
        end
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                p32[i][j] = {32'b0, p16[2*i][2*j]}
                          + ({32'b0, p16[2*i][2*j+1]} << 16)
                          + ({32'b0, p16[2*i+1][2*j]} << 16)
                          + {p16[2*i+1][2*j+1], 32'b0};
            end
        end
    end

    // only the diagonal products carry element results below 64 bits
    logic [15:0] p8d_2  [8];
    logic [31:0] p16d_2 [4];
    logic [63:0] p32_2  [2][2];

    always_ff @(posedge clk_i) begin
        mag1_1 <= mag1_0;
        mag2_1 <= mag2_0;
        for (int i = 0; i < 8; i++) begin
            p8d_2[i] <= p8[i][i];
        end
        for (int i = 0; i < 4; i++) begin
            p16d_2[i] <= p16[i][i];
        end
        p32_2 <= p32;
    end

    ////////////////////
    // stage 2
    ////////////////////
    logic [127:0] p64_2;
    logic [15:0]  r16;
    logic [31:0]  r32;
    logic [63:0]  r64;
    logic [127:0] r128;

    assign p64_2 = {64'b0, p32_2[0][0]}
                 + ({64'b0, p32_2[0][1]} << 32)
                 + ({64'b0, p32_2[1][0]} << 32)
                 + {p32_2[1][1], 64'b0};

    // re-negate, then pick the high or low half per element
    always_comb begin
        r16       = '0;
        r32       = '0;
        r64       = '0;
        r128      = '0;
        data_vd_o = '0;
        case (sew_2)
            SEW_8: for (int i = 0; i < 8; i++) begin
                r16 = neg_2[i] ? -p8d_2[i] : p8d_2[i];
                data_vd_o[i*8+:8] = mulh_2 ? r16[15:8] : r16[7:0];
            end
            SEW_16: for (int i = 0; i < 4; i++) begin
                r32 = neg_2[i] ? -p16d_2[i] : p16d_2[i];
                data_vd_o[i*16+:16] = mulh_2 ? r32[31:16] : r32[15:0];
            end
            SEW_32: for (int i = 0; i < 2; i++) begin
                r64 = neg_2[i] ? -p32_2[i][i] : p32_2[i][i];
                data_vd_o[i*32+:32] = mulh_2 ? r64[63:32] : r64[31:0];
            end
            default: begin
                r128      = neg_2[0] ? -p64_2 : p64_2;
                data_vd_o = mulh_2 ? r128[127:64] : r128[63:0];
            end
        endcase
    end

    sew_known_a: assert property (@(posedge clk_i) disable iff (!rstn_i) !$isunknown(sew_i));

endmodule

/* hdl/vrf_arbiter.sv */
////////////////////
// vector register file with a round-robin arbiter between host and sequencer
////////////////////
module vrf_arbiter import vmul_pkg::*; (
    input  logic   clk_i,
    input  logic   rstn_i,
    vrf_if.arbiter host_port,
    vrf_if.arbiter seq_port
);

    bus64_t             regs_q [VREG_NUM];
    logic               last_host_q;
    logic               wr_en;
    logic [VREG_AW-1:0] wr_addr;
    bus64_t             wr_data;

    // host wins unless it had the last grant and the sequencer is waiting
    assign host_port.gnt = host_port.req && (!seq_port.req || !last_host_q);
    assign seq_port.gnt  = seq_port.req && !host_port.gnt;

    assign wr_en   = (host_port.gnt && host_port.we) || (seq_port.gnt && seq_port.we);
    assign wr_addr = host_port.gnt ? host_port.addr : seq_port.addr;
    assign wr_data = host_port.gnt ? host_port.wdata : seq_port.wdata;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            last_host_q <= 1'b0;
            for (int i = 0; i < VREG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (host_port.gnt) begin
                last_host_q <= 1'b1;
            end else if (seq_port.gnt) begin
                last_host_q <= 1'b0;
            end
            if (wr_en) begin
                regs_q[wr_addr] <= wr_data;
            end
        end
    end

    // read data lands one cycle after the grant
    always_ff @(posedge clk_i) begin
        if (host_port.gnt && !host_port.we) begin
            host_port.rdata <= regs_q[host_port.addr];
        end
        if (seq_port.gnt && !seq_port.we) begin
            seq_port.rdata <= regs_q[seq_port.addr];
        end
    end

    // a port held off by the other one is served in the next cycle
    host_wait_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        host_port.req && !host_port.gnt |=> host_port.gnt);
    seq_wait_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        seq_port.req && !seq_port.gnt |=> seq_port.gnt);

endmodule

/* hdl/vmul_seq.sv */
////////////////////
// runs one multiply command: read vs1 and vs2, multiply, write vd
////////////////////
module vmul_seq import vmul_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     cmd_valid_i,
    input  bus64_t   cmd_word_i,
    output logic     busy_o,
    vrf_if.requester vrf
);

    seq_state_t         state_q;
    vmul_op_t           op_q;
    sew_t               sew_q;
    logic [VREG_AW-1:0] vd_q;
    logic [VREG_AW-1:0] vs1_q;
    logic [VREG_AW-1:0] vs2_q;
    logic [1:0]         wait_q;
    logic               mul_done;
    bus64_t             src1_q;
    bus64_t             res_q;
    bus64_t             mul_res;

    // vs2 comes straight from rdata during ISSUE
    vmul u_vmul (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .op_i       (op_q),
        .sew_i      (sew_q),
        .data_vs1_i (src1_q),
        .data_vs2_i (vrf.rdata),
        .data_vd_o  (mul_res)
    );

    assign mul_done  = (state_q == WAIT_MUL) && (wait_q == 2'(MUL_LATENCY - 1));
    assign busy_o    = (state_q != IDLE);
    assign vrf.req   = (state_q == RD_VS1) || (state_q == RD_VS2) || (state_q == WR_VD);
    assign vrf.we    = (state_q == WR_VD);
    assign vrf.addr  = (state_q == RD_VS1) ? vs1_q : (state_q == RD_VS2) ? vs2_q : vd_q;
    assign vrf.wdata = res_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            op_q    <= VMUL;
            sew_q   <= SEW_8;
            vd_q    <= '0;
            vs1_q   <= '0;
            vs2_q   <= '0;
            wait_q  <= '0;
        end else begin
            case (state_q)
                IDLE: if (cmd_valid_i) begin
                    op_q    <= vmul_op_t'(cmd_word_i[CMD_OP_LSB +: 2]);
                    sew_q   <= sew_t'(cmd_word_i[CMD_SEW_LSB +: 2]);
                    vd_q    <= cmd_word_i[CMD_VD_LSB +: VREG_AW];
                    vs1_q   <= cmd_word_i[CMD_VS1_LSB +: VREG_AW];
                    vs2_q   <= cmd_word_i[CMD_VS2_LSB +: VREG_AW];
                    state_q <= RD_VS1;
                end
                RD_VS1: if (vrf.gnt) state_q <= RD_VS2;
                RD_VS2: if (vrf.gnt) state_q <= ISSUE;
                ISSUE: begin
                    wait_q  <= '0;
                    state_q <= WAIT_MUL;
                end
                WAIT_MUL: begin
                    wait_q <= wait_q + 2'd1;
                    if (mul_done) state_q <= WR_VD;
                end
                WR_VD: if (vrf.gnt) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        // rdata still holds vs1 until the vs2 read is granted
        if (state_q == RD_VS2 && vrf.gnt) begin
            src1_q <= vrf.rdata;
        end
        if (mul_done) begin
            res_q <= mul_res;
        end
    end

    no_cmd_busy_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd_valid_i |-> !busy_o);

endmodule

/* hdl/axil_vmul_slave.sv */
////////////////////
// AXI4-Lite slave for the register file window, command and status registers
// one transaction at a time and writes win over reads
////////////////////
module axil_vmul_slave import vmul_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              s_awvalid_i,
    output logic              s_awready_o,
    input  logic [AXI_AW-1:0] s_awaddr_i,
    input  logic              s_wvalid_i,
    output logic              s_wready_o,
    input  logic [AXI_DW-1:0] s_wdata_i,
    output logic              s_bvalid_o,
    input  logic              s_bready_i,
    output logic [1:0]        s_bresp_o,
    input  logic              s_arvalid_i,
    output logic              s_arready_o,
    input  logic [AXI_AW-1:0] s_araddr_i,
    output logic              s_rvalid_o,
    input  logic              s_rready_i,
    output logic [AXI_DW-1:0] s_rdata_o,
    output logic [1:0]        s_rresp_o,
    output logic              cmd_valid_o,
    output bus64_t            cmd_word_o,
    input  logic              busy_i,
    vrf_if.requester          vrf
);

    typedef enum logic [1:0] {S_IDLE, S_VRF, S_BRESP, S_RRESP} slv_state_t;

    slv_state_t         state_q;
    logic               we_q;
    logic               rd_vrf_q;
    logic               cmd_valid_q;
    logic [1:0]         resp_q;
    logic [VREG_AW-1:0] idx_q;
    bus64_t             wdata_q;
    bus64_t             rdata_q;
    logic               wr_hs;
    logic               rd_hs;

    // aligned address inside the register window
    function automatic logic is_vreg(input logic [AXI_AW-1:0] a);
        logic [AXI_AW-1:0] off;
        off = a - VREG_BASE;
        return (off < AXI_AW'(VREG_NUM * 8)) && (off[2:0] == 3'b0);
    endfunction

    function automatic logic [VREG_AW-1:0] vreg_idx(input logic [AXI_AW-1:0] a);
        logic [AXI_AW-1:0] off;
        off = a - VREG_BASE;
        return off[3 +: VREG_AW];
    endfunction

    assign wr_hs       = (state_q == S_IDLE) && s_awvalid_i && s_wvalid_i;
    assign rd_hs       = (state_q == S_IDLE) && s_arvalid_i && !wr_hs;
    assign s_awready_o = wr_hs;
    assign s_wready_o  = wr_hs;
    assign s_arready_o = rd_hs;
    assign s_bvalid_o  = (state_q == S_BRESP);
    assign s_rvalid_o  = (state_q == S_RRESP);
    assign s_bresp_o   = resp_q;
    assign s_rresp_o   = resp_q;
    assign s_rdata_o   = rd_vrf_q ? vrf.rdata : rdata_q;
    assign cmd_valid_o = cmd_valid_q;
    assign cmd_word_o  = wdata_q;

    assign vrf.req   = (state_q == S_VRF);
    assign vrf.we    = we_q;
    assign vrf.addr  = idx_q;
    assign vrf.wdata = wdata_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= S_IDLE;
            we_q        <= 1'b0;
            rd_vrf_q    <= 1'b0;
            cmd_valid_q <= 1'b0;
            resp_q      <= RESP_OKAY;
        end else begin
            cmd_valid_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (wr_hs) begin
                        we_q    <= 1'b1;
                        resp_q  <= RESP_OKAY;
                        state_q <= S_BRESP;
                        if (is_vreg(s_awaddr_i)) begin
                            state_q <= S_VRF;
                        end else if (s_awaddr_i == CMD_ADDR && !busy_i) begin
                            cmd_valid_q <= 1'b1;
                        end else begin
                            // busy command, status write or unmapped
                            resp_q <= RESP_SLVERR;
                        end
                    end else if (rd_hs) begin
                        we_q     <= 1'b0;
                        resp_q   <= RESP_OKAY;
                        rd_vrf_q <= is_vreg(s_araddr_i);
                        state_q  <= is_vreg(s_araddr_i) ? S_VRF : S_RRESP;
                        if (!is_vreg(s_araddr_i) && s_araddr_i != STATUS_ADDR) begin
                            resp_q <= RESP_SLVERR;
                        end
                    end
                end
                S_VRF: if (vrf.gnt) state_q <= we_q ? S_BRESP : S_RRESP;
                S_BRESP: if (s_bready_i) state_q <= S_IDLE;
                S_RRESP: if (s_rready_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // address and data capture at the handshake
    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            wdata_q <= s_wdata_i;
            idx_q   <= vreg_idx(s_awaddr_i);
        end else if (rd_hs) begin
            idx_q   <= vreg_idx(s_araddr_i);
            rdata_q <= (s_araddr_i == STATUS_ADDR) ? AXI_DW'(busy_i) : '0;
        end
    end

    // read data stays put while the host stalls rready
    rdata_hold_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_rvalid_o && !s_rready_i |=> $stable(s_rdata_o));

endmodule

/* hdl/vmul_top.sv */
////////////////////
// coprocessor top: AXI4-Lite slave, sequencer and shared register file
////////////////////
module vmul_top import vmul_pkg::*; (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              s_awvalid_i,
    output logic              s_awready_o,
    input  logic [AXI_AW-1:0] s_awaddr_i,
    input  logic              s_wvalid_i,
    output logic              s_wready_o,
    input  logic [AXI_DW-1:0] s_wdata_i,
    output logic              s_bvalid_o,
    input  logic              s_bready_i,
    output logic [1:0]        s_bresp_o,
    input  logic              s_arvalid_i,
    output logic              s_arready_o,
    input  logic [AXI_AW-1:0] s_araddr_i,
    output logic              s_rvalid_o,
    input  logic              s_rready_i,
    output logic [AXI_DW-1:0] s_rdata_o,
    output logic [1:0]        s_rresp_o
);

    vrf_if  host_port ();
    vrf_if  seq_port ();
    logic   cmd_valid;
    bus64_t cmd_word;
    logic   busy;

    // AXI ports by name match
    axil_vmul_slave u_slave (
        .*,
        .cmd_valid_o (cmd_valid),
        .cmd_word_o  (cmd_word),
        .busy_i      (busy),
        .vrf         (host_port)
    );

    vmul_seq u_seq (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cmd_valid_i (cmd_valid),
        .cmd_word_i  (cmd_word),
        .busy_o      (busy),
        .vrf         (seq_port)
    );

    vrf_arbiter u_arb (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .host_port (host_port),
        .seq_port  (seq_port)
    );

endmodule

/* test/tb_clkgen.sv */
////////////////////
// clock and reset for the testbench, 4 ns period
////////////////////
module tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held low for four clock cycles
    initial begin
        rstn_o = 1'b0;
        repeat (4) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

/* test/tb_vmul.sv */
////////////////////
// testbench for the vector multiply coprocessor
// drives the AXI4-Lite port with vectors from test/vmul_stim.txt
////////////////////
module tb_vmul import vmul_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rstn;
    logic              s_awvalid;
    logic              s_awready;
    logic [AXI_AW-1:0] s_awaddr;
    logic              s_wvalid;
    logic              s_wready;
    logic [AXI_DW-1:0] s_wdata;
    logic              s_bvalid;
    logic              s_bready;
    logic [1:0]        s_bresp;
    logic              s_arvalid;
    logic              s_arready;
    logic [AXI_AW-1:0] s_araddr;
    logic              s_rvalid;
    logic              s_rready;
    logic [AXI_DW-1:0] s_rdata;
    logic [1:0]        s_rresp;

    // vectors from the stimulus file
    logic [1:0]  vec_op  [$];
    logic [1:0]  vec_sew [$];
    bus64_t      vec_a   [$];
    bus64_t      vec_b   [$];
    bus64_t      vec_exp [$];

    int          err_cnt     = 0;
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    logic        stall_en;

    tb_clkgen u_clkgen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    vmul_top uut (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_awaddr_i  (s_awaddr),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_wdata_i   (s_wdata),
        .s_bvalid_o  (s_bvalid),
        .s_bready_i  (s_bready),
        .s_bresp_o   (s_bresp),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_araddr_i  (s_araddr),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready),
        .s_rdata_o   (s_rdata),
        .s_rresp_o   (s_rresp)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic check_val(input string name, input bus64_t got, input bus64_t exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int err0);
        if (err_cnt == err0) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", name, err_cnt - err0);
        end
    endtask

    function automatic logic [AXI_AW-1:0] vreg_addr(input int k);
        return VREG_BASE + AXI_AW'(k * 8);
    endfunction

    // rotated byte pattern that differs for every register
    function automatic bus64_t reg_pattern(input int k);
        bus64_t base;
        base = 64'h0123_4567_89ab_cdef;
        return 64'({base, base} >> (k * 8));
    endfunction

    // sources always v1 and v2
    function automatic bus64_t cmd_word(input logic [1:0] op, input logic [1:0] sew,
                                        input int vd);
        bus64_t w;
        w = '0;
        w[CMD_OP_LSB +: 2]        = op;
        w[CMD_SEW_LSB +: 2]       = sew;
        w[CMD_VD_LSB +: VREG_AW]  = VREG_AW'(vd);
        w[CMD_VS1_LSB +: VREG_AW] = VREG_AW'(1);
        w[CMD_VS2_LSB +: VREG_AW] = VREG_AW'(2);
        return w;
    endfunction

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        int unsigned op_v;
        int unsigned sew_v;
        bus64_t      a_v;
        bus64_t      b_v;
        bus64_t      e_v;
        fd = $fopen("test/vmul_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/vmul_stim.txt");
            err_cnt++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // comment lines do not parse and are skipped
                n = $sscanf(line, "%h %h %h %h %h", op_v, sew_v, a_v, b_v, e_v);
                if (n == 5) begin
                    vec_op.push_back(op_v[1:0]);
                    vec_sew.push_back(sew_v[1:0]);
                    vec_a.push_back(a_v);
                    vec_b.push_back(b_v);
                    vec_exp.push_back(e_v);
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////
    // AXI4-Lite access
    ////////////////////
    task automatic write_word(input logic [AXI_AW-1:0] addr, input bus64_t data,
                              input logic [1:0] exp_resp);
        int stall;
        stall = stall_en ? int'($urandom_range(3, 0)) : 0;
        @(posedge clk);
        s_awvalid <= 1'b1;
        s_awaddr  <= addr;
        s_wvalid  <= 1'b1;
        s_wdata   <= data;
        @(negedge clk);
        while (!(s_awready && s_wready)) @(negedge clk);
        @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        @(negedge clk);
        while (!s_bvalid) @(negedge clk);
        // response waits while bready is held low
        repeat (stall) @(negedge clk);
        @(posedge clk);
        s_bready <= 1'b1;
        @(negedge clk);
        assert (s_bvalid === 1'b1) else begin
            $display("write response was dropped before bready was raised");
            err_cnt++;
        end
        check_val("s_bresp_o", 64'(s_bresp), 64'(exp_resp));
        @(posedge clk);
        s_bready <= 1'b0;
    endtask

    task automatic read_word(input logic [AXI_AW-1:0] addr, input logic [1:0] exp_resp,
                             output bus64_t data);
        int     stall;
        bus64_t first;
        stall = stall_en ? int'($urandom_range(3, 0)) : 0;
        @(posedge clk);
        s_arvalid <= 1'b1;
        s_araddr  <= addr;
        @(negedge clk);
        while (!s_arready) @(negedge clk);
        @(posedge clk);
        s_arvalid <= 1'b0;
        @(negedge clk);
        while (!s_rvalid) @(negedge clk);
        first = s_rdata;
        repeat (stall) @(negedge clk);
        @(posedge clk);
        s_rready <= 1'b1;
        @(negedge clk);
        assert (s_rvalid === 1'b1) else begin
            $display("read response was dropped before rready was raised");
            err_cnt++;
        end
        // data must not move during the stall
        check_val("s_rdata_o", s_rdata, first);
        check_val("s_rresp_o", 64'(s_rresp), 64'(exp_resp));
        data = s_rdata;
        @(posedge clk);
        s_rready <= 1'b0;
    endtask

    task automatic wait_idle();
        bus64_t status;
        status = 64'd1;
        while (status[0]) begin
            read_word(STATUS_ADDR, RESP_OKAY, status);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic reset_state();
        int err0;
        err0 = err_cnt;
        @(negedge clk);
        check_val("s_awready_o", 64'(s_awready), 64'd0);
        check_val("s_wready_o", 64'(s_wready), 64'd0);
        check_val("s_arready_o", 64'(s_arready), 64'd0);
        check_val("s_bvalid_o", 64'(s_bvalid), 64'd0);
        check_val("s_rvalid_o", 64'(s_rvalid), 64'd0);
        end_test("outputs after reset", err0);
    endtask

    task automatic regfile_rw();
        int     err0;
        bus64_t data;
        err0 = err_cnt;
        for (int k = 0; k < VREG_NUM; k++) begin
            write_word(vreg_addr(k), reg_pattern(k), RESP_OKAY);
        end
        for (int k = 0; k < VREG_NUM; k++) begin
            read_word(vreg_addr(k), RESP_OKAY, data);
            check_val($sformatf("s_rdata_o v%0d", k), data, reg_pattern(k));
        end
        end_test("register write and readback", err0);
    endtask

    task automatic multiply_vector(input int i);
        int     err0;
        bus64_t data;
        err0 = err_cnt;
        write_word(vreg_addr(1), vec_a[i], RESP_OKAY);
        write_word(vreg_addr(2), vec_b[i], RESP_OKAY);
        write_word(CMD_ADDR, cmd_word(vec_op[i], vec_sew[i], 3), RESP_OKAY);
        wait_idle();
        read_word(vreg_addr(3), RESP_OKAY, data);
        check_val("s_rdata_o v3", data, vec_exp[i]);
        // sources untouched by the command
        read_word(vreg_addr(1), RESP_OKAY, data);
        check_val("s_rdata_o v1", data, vec_a[i]);
        read_word(vreg_addr(2), RESP_OKAY, data);
        check_val("s_rdata_o v2", data, vec_b[i]);
        end_test($sformatf("vector %0d op %0d sew %0d", i, vec_op[i], vec_sew[i]), err0);
    endtask

    task automatic busy_reject();
        int     err0;
        bus64_t data;
        err0 = err_cnt;
        stall_en = 1'b0;
        write_word(vreg_addr(1), vec_a[0], RESP_OKAY);
        write_word(vreg_addr(2), vec_b[0], RESP_OKAY);
        write_word(CMD_ADDR, cmd_word(vec_op[0], vec_sew[0], 3), RESP_OKAY);
        // second command arrives while the first one runs
        write_word(CMD_ADDR, cmd_word(2'd2, 2'd3, 3), RESP_SLVERR);
        stall_en = 1'b1;
        wait_idle();
        read_word(vreg_addr(3), RESP_OKAY, data);
        check_val("s_rdata_o v3", data, vec_exp[0]);
        end_test("command while busy", err0);
    endtask

    task automatic unmapped_access();
        int     err0;
        bus64_t data;
        err0 = err_cnt;
        write_word(7'h50, 64'h5a5a_a5a5_0f0f_f0f0, RESP_SLVERR);
        read_word(7'h50, RESP_SLVERR, data);
        check_val("s_rdata_o", data, 64'd0);
        end_test("unmapped address", err0);
    endtask

    initial begin
        s_awvalid = 1'b0;
        s_awaddr  = '0;
        s_wvalid  = 1'b0;
        s_wdata   = '0;
        s_bready  = 1'b0;
        s_arvalid = 1'b0;
        s_araddr  = '0;
        s_rready  = 1'b0;
        stall_en  = 1'b1;
        void'($urandom(32'h00aecb09));
        load_stim();
        cycle_limit = vec_op.size() * 80 + 200;
        wait (rstn === 1'b1);
        if (vec_op.size() == 0) begin
            $display("no test vectors were found in the stimulus file");
            err_cnt++;
        end else begin
            reset_state();
            regfile_rw();
            for (int i = 0; i < vec_op.size(); i++) begin
                multiply_vector(i);
            end
            busy_reject();
            unmapped_access();
        end
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* test/vmul_stim.txt */
# columns in hex: op sew a b expected
# op 0 vmul, 1 vmulh, 2 vmulhu, 3 vmulhsu; sew 0 8-bit, 1 16-bit, 2 32-bit, 3 64-bit
0 0 80FF7F02FE100003 80FFFF8103F0557F 00018102FA00007D
1 0 80FF7F02FE100003 80FFFF8103F0557F 4000FFFFFFFF0001
2 0 80FF7F02FE100003 80FFFF8103F0557F 40FE7E01020F0001
3 0 80FF7F02FE100003 80FFFF8103F0557F C0FF7E01FF0F0001
0 1 8000FFFF7FFF1234 80000002FFFFFFFE 0000FFFE8001DB98
1 1 8000FFFF7FFF1234 80000002FFFFFFFE 4000FFFFFFFFFFFF
2 1 8000FFFF7FFF1234 80000002FFFFFFFE 400000017FFE1233
3 1 8000FFFF7FFF1234 80000002FFFFFFFE C000FFFF7FFE1233
0 2 8000000012345678 FFFFFFFFFFFFFFF0 80000000DCBA9880
1 2 8000000012345678 FFFFFFFFFFFFFFF0 00000000FFFFFFFE
2 2 8000000012345678 FFFFFFFFFFFFFFF0 7FFFFFFF12345676
3 2 8000000012345678 FFFFFFFFFFFFFFF0 8000000012345676
0 3 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
1 3 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000
2 3 8000000000000000 FFFFFFFFFFFFFFFF 7FFFFFFFFFFFFFFF
3 3 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000
1 3 FFFFFFFFFFFFFFFE 0000000000000003 FFFFFFFFFFFFFFFF
2 3 FFFFFFFFFFFFFFFE 0000000000000003 0000000000000002
0 3 0123456789ABCDEF FFFFFFFFFFFFFFFF FEDCBA9876543211
3 3 0123456789ABCDEF FFFFFFFFFFFFFFFF 0123456789ABCDEE

/* filelist.f */
hdl/vmul_pkg.sv
hdl/vrf_if.sv
hdl/vmul.sv
hdl/vrf_arbiter.sv
hdl/vmul_seq.sv
hdl/axil_vmul_slave.sv
hdl/vmul_top.sv
test/tb_clkgen.sv
test/tb_vmul.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_vmul -f filelist.f -o vmul_sim

out="$(./obj_dir/vmul_sim)"
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
